// File: logic/chipset_data_bus.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read-back to the CPU, one clock behind the bus. Interrupt acknowledge
// wins over every port read. LPT data latch powers up as FFh.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module chipset_data_bus
    import xt_bus_pkg::*;
    import xt_ems_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  cpu_bus_t     bus_i,
    input  io_select_t   select_i,
    input  ems_map_t     ems_map_i,
    input  periph_data_t periph_data_i,
    output logic [7:0]   data_bus_o,
    output logic         data_bus_drive_o
);

    logic [7:0] lpt_data;
    ems_entry_t ems_read_entry;
    logic [7:0] ems_read_data;
    logic       io_read;

    assign io_read        = ~bus_i.io_read_n;
    assign ems_read_entry = ems_map_i[bus_i.address[1:0]];
    assign ems_read_data  = ems_read_entry.enable ? {1'b0, ems_read_entry.page}
                                                  : EMS_DISABLE_CODE;

    // Parallel port data latch
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_data <= 8'hFF;
        end
        else if (select_i.lpt && ~bus_i.io_write_n) begin
            lpt_data <= bus_i.data;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            data_bus_drive_o <= 1'b0;
            data_bus_o       <= 8'h00;
        end
        else begin
            data_bus_drive_o <= 1'b1;
            if (~bus_i.interrupt_acknowledge_n) begin
                // Vector from the 8259
                data_bus_o <= periph_data_i.intc;
            end
            else if (select_i.intc && io_read) begin
                data_bus_o <= periph_data_i.intc;
            end
            else if (select_i.timer && io_read) begin
                data_bus_o <= periph_data_i.timer;
            end
            else if (select_i.ppi && io_read) begin
                data_bus_o <= periph_data_i.ppi;
            end
            else if (select_i.ems && io_read) begin
                data_bus_o <= ems_read_data;
            end
            else if (select_i.lpt && io_read) begin
                data_bus_o <= lpt_data;
            end
            else begin
                data_bus_drive_o <= 1'b0;
                data_bus_o       <= 8'h00;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/ems_mapper.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// EMS page registers. A write sampled at one edge lands one edge later.
// Back-to-back writes to one register resolve against the old entry.
// Window hits are combinational and only on non-I/O cycles.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ems_mapper
    import xt_bus_pkg::*;
    import xt_ems_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  cpu_bus_t                  bus_i,
    input  logic                      ems_select_i,
    input  logic [1:0]                ems_base_i,
    output ems_map_t                  ems_map_o,
    output logic [EMS_PAGE_COUNT-1:0] ems_window_o
);

    ems_write_u  write_byte;
    ems_entry_t  current_entry;
    ems_entry_t  resolved_entry;
    ems_entry_t  pending_entry;
    logic [1:0]  pending_index;
    logic        pending_write;
    logic        io_request;
    logic [3:0]  window_base;

    assign write_byte.raw = bus_i.data;
    assign current_entry  = ems_map_o[bus_i.address[1:0]];

    // Decode the written byte
    always_comb begin
        if (write_byte.raw == EMS_DISABLE_CODE) begin
            resolved_entry.enable = 1'b0;
            resolved_entry.page   = 7'h7F;
        end
        else if (~write_byte.cmd.command) begin
            resolved_entry.enable = 1'b1;
            resolved_entry.page   = write_byte.cmd.page;
        end
        else begin
            // 80h-FEh leave the entry alone
            resolved_entry = current_entry;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            pending_write <= 1'b0;
        end
        else begin
            pending_write <= ems_select_i & ~bus_i.io_write_n;
        end
    end

    always_ff @(posedge clock) begin
        pending_index <= bus_i.address[1:0];
        pending_entry <= resolved_entry;
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            ems_map_o <= '0;
        end
        else if (pending_write) begin
            ems_map_o[pending_index] <= pending_entry;
        end
    end

    // Memory windows
    assign io_request = ~bus_i.io_read_n | ~bus_i.io_write_n;

    always_comb begin
        case (ems_base_i)
            2'd0:    window_base = EMS_BASE_A;
            2'd1:    window_base = EMS_BASE_C;
            default: window_base = EMS_BASE_D;
        endcase
    end

    always_comb begin
        for (int i = 0; i < EMS_PAGE_COUNT; i++) begin
            ems_window_o[i] = ~io_request & ems_map_o[i].enable
                            & (bus_i.address[19:14] == {window_base, 2'(i)});
        end
    end

endmodule

`default_nettype wire

// File: logic/keyboard_sync.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Keyboard scancode and IRQ into the system clock, two stages deep.
// Scancode bits are not sampled as a group; keep them stable around IRQ.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module keyboard_sync (
    input  logic       clock,
    input  logic       reset,
    input  logic [7:0] keycode_i,
    input  logic       keyboard_irq_i,
    output logic [7:0] port_a_o,
    output logic       keyboard_interrupt_o
);

    logic [7:0] keycode_meta;
    logic       irq_meta;

    // Scancode to PPI port A
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            keycode_meta <= 8'h00;
            port_a_o     <= 8'h00;
        end
        else begin
            keycode_meta <= keycode_i;
            port_a_o     <= keycode_meta;
        end
    end

    // IRQ1 request to the 8259
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            irq_meta             <= 1'b0;
            keyboard_interrupt_o <= 1'b0;
        end
        else begin
            irq_meta             <= keyboard_irq_i;
            keyboard_interrupt_o <= irq_meta;
        end
    end

endmodule

`default_nettype wire

// File: logic/port_decoder.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational I/O decode. Chipset slots cover 000h-0FFh only,
// slots 5 to 7 are unassigned. EMS ports need ems_enabled_i.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module port_decoder
    import xt_bus_pkg::*;
(
    input  cpu_bus_t   bus_i,
    input  logic       ems_enabled_i,
    output io_select_t select_o
);

    logic                          io_request;
    logic                          port_cycle;
    logic [CHIPSET_SLOT_COUNT-1:0] slot_hit;

    assign io_request = ~bus_i.io_read_n | ~bus_i.io_write_n;
    assign port_cycle = io_request & ~bus_i.address_enable_n;

    // One-hot slot from address bits 7:5
    always_comb begin
        slot_hit = '0;
        if (~bus_i.address_enable_n && (bus_i.address[9:8] == 2'b00)) begin
            slot_hit[bus_i.address[7:5]] = 1'b1;
        end
    end

    always_comb begin
        select_o.dma      = io_request & slot_hit[0];
        select_o.intc     = io_request & slot_hit[1];
        select_o.timer    = io_request & slot_hit[2];
        select_o.ppi      = io_request & slot_hit[3];
        select_o.dma_page = io_request & slot_hit[4];

        // 260h-263h
        select_o.ems = port_cycle & ems_enabled_i
                     & (bus_i.address[15:2] == EMS_PORT_BASE[15:2]);

        // 378h-37Fh
        select_o.lpt = port_cycle & (bus_i.address[15:3] == LPT_PORT_BASE[15:3]);
    end

endmodule

`default_nettype wire

// File: logic/timer_clock_gen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Timer clock at half the peripheral clock rate. Each peripheral
// level must last at least 3 system clocks to be seen.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module timer_clock_gen (
    input  logic clock,
    input  logic reset,
    input  logic peripheral_clock_i,
    output logic timer_clock_o
);

    logic sync_meta;
    logic sync_stable;
    logic sync_prev;
    logic rise;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            sync_meta   <= 1'b0;
            sync_stable <= 1'b0;
            sync_prev   <= 1'b0;
        end
        else begin
            sync_meta   <= peripheral_clock_i;
            sync_stable <= sync_meta;
            sync_prev   <= sync_stable;
        end
    end

    assign rise = sync_stable & ~sync_prev;

    // Toggles on the third edge after the input rises
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            timer_clock_o <= 1'b0;
        end
        else if (rise) begin
            timer_clock_o <= ~timer_clock_o;
        end
    end

endmodule

`default_nettype wire

// File: logic/xt_bus_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU bus, chip select and peripheral read data types of the XT glue.
// Bus strobes keep their ISA polarity (active low); selects are
// active high.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package xt_bus_pkg;

    // I/O port map
    localparam logic [15:0] EMS_PORT_BASE      = 16'h0260;
    localparam logic [15:0] LPT_PORT_BASE      = 16'h0378;
    // 32-byte chipset slots below 100h
    localparam logic [15:0] CHIPSET_SLOT_COUNT = 16'd8;

    typedef struct packed {
        logic [19:0] address;
        logic [7:0]  data;
        logic        io_read_n;
        logic        io_write_n;
        logic        memory_read_n;
        logic        address_enable_n;
        logic        interrupt_acknowledge_n;
    } cpu_bus_t;

    typedef struct packed {
        logic dma;
        logic intc;
        logic timer;
        logic ppi;
        logic dma_page;
        logic ems;
        logic lpt;
    } io_select_t;

    // Read data of the external 8259, 8253 and 8255
    typedef struct packed {
        logic [7:0] intc;
        logic [7:0] timer;
        logic [7:0] ppi;
    } periph_data_t;

endpackage

`default_nettype wire

// File: logic/xt_ems_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// EMS page register types. Four 16 KB windows, 7-bit page numbers.
// Window base is Ah, Ch or Dh (A0000h, C0000h, D0000h).
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package xt_ems_pkg;

    localparam logic [7:0] EMS_DISABLE_CODE = 8'hFF;
    localparam int         EMS_PAGE_COUNT   = 4;
    localparam logic [3:0] EMS_BASE_A       = 4'hA;
    localparam logic [3:0] EMS_BASE_C       = 4'hC;
    localparam logic [3:0] EMS_BASE_D       = 4'hD;

    typedef struct packed {
        logic       enable;
        logic [6:0] page;
    } ems_entry_t;

    typedef ems_entry_t [EMS_PAGE_COUNT-1:0] ems_map_t;

    // Byte written to a page register
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic       command;    // low means map and enable
            logic [6:0] page;
        } cmd;
    } ems_write_u;

endpackage

`default_nettype wire

// File: logic/xt_glue_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PC/XT peripheral glue. The 8259, 8253 and 8255 sit outside; their
// selects leave on select_o and their read data enters on periph_data_i.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module xt_glue_top
    import xt_bus_pkg::*;
    import xt_ems_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  cpu_bus_t                  bus_i,
    input  logic                      ems_enabled_i,
    input  logic [1:0]                ems_base_i,
    input  logic                      peripheral_clock_i,
    input  logic [7:0]                keycode_i,
    input  logic                      keyboard_irq_i,
    input  periph_data_t              periph_data_i,
    output io_select_t                select_o,
    output ems_map_t                  ems_map_o,
    output logic [EMS_PAGE_COUNT-1:0] ems_window_o,
    output logic                      timer_clock_o,
    output logic [7:0]                port_a_o,
    output logic                      keyboard_interrupt_o,
    output logic [7:0]                data_bus_o,
    output logic                      data_bus_drive_o
);

    port_decoder u_port_decoder (
        .bus_i         (bus_i),
        .ems_enabled_i (ems_enabled_i),
        .select_o      (select_o)
    );

    ems_mapper u_ems_mapper (
        .clock        (clock),
        .reset        (reset),
        .bus_i        (bus_i),
        .ems_select_i (select_o.ems),
        .ems_base_i   (ems_base_i),
        .ems_map_o    (ems_map_o),
        .ems_window_o (ems_window_o)
    );

    timer_clock_gen u_timer_clock_gen (
        .clock              (clock),
        .reset              (reset),
        .peripheral_clock_i (peripheral_clock_i),
        .timer_clock_o      (timer_clock_o)
    );

    keyboard_sync u_keyboard_sync (
        .clock                (clock),
        .reset                (reset),
        .keycode_i            (keycode_i),
        .keyboard_irq_i       (keyboard_irq_i),
        .port_a_o             (port_a_o),
        .keyboard_interrupt_o (keyboard_interrupt_o)
    );

    chipset_data_bus u_chipset_data_bus (
        .clock            (clock),
        .reset            (reset),
        .bus_i            (bus_i),
        .select_i         (select_o),
        .ems_map_i        (ems_map_o),
        .periph_data_i    (periph_data_i),
        .data_bus_o       (data_bus_o),
        .data_bus_drive_o (data_bus_drive_o)
    );

endmodule

`default_nettype wire

// File: sources.f
+incdir+test
logic/xt_bus_pkg.sv
logic/xt_ems_pkg.sv
logic/port_decoder.sv
logic/ems_mapper.sv
logic/timer_clock_gen.sv
logic/keyboard_sync.sv
logic/chipset_data_bus.sv
logic/xt_glue_top.sv
test/tb_xt_glue.sv

// File: test/xt_glue_model.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of the XT glue decode, EMS and read-back rules.
// Included inside the testbench module, after the package imports.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef XT_GLUE_MODEL_SVH
`define XT_GLUE_MODEL_SVH

function automatic io_select_t expect_select(cpu_bus_t b, logic ems_on);
    io_select_t s;
    logic       io_req;
    logic       chip_cycle;
    logic [2:0] slot;
    io_req     = !b.io_read_n || !b.io_write_n;
    slot       = b.address[7:5];
    chip_cycle = io_req && !b.address_enable_n && (b.address[9:8] == 2'b00);
    s          = '0;
    s.dma      = chip_cycle && (slot == 3'd0);
    s.intc     = chip_cycle && (slot == 3'd1);
    s.timer    = chip_cycle && (slot == 3'd2);
    s.ppi      = chip_cycle && (slot == 3'd3);
    s.dma_page = chip_cycle && (slot == 3'd4);
    s.ems = io_req && !b.address_enable_n && ems_on
            && (b.address[15:2] == EMS_PORT_BASE[15:2]);
    s.lpt = io_req && !b.address_enable_n && (b.address[15:3] == LPT_PORT_BASE[15:3]);
    return s;
endfunction

// New page register value for a written byte
function automatic ems_entry_t resolve_ems_write(logic [7:0] value, ems_entry_t old);
    ems_entry_t e;
    if (value == 8'hFF) begin
        e.enable = 1'b0;
        e.page   = 7'h7F;
    end
    else if (value < 8'h80) begin
        e.enable = 1'b1;
        e.page   = value[6:0];
    end
    else begin
        e = old;
    end
    return e;
endfunction

function automatic logic [3:0] expect_window(cpu_bus_t b, logic [1:0] base_code,
                                             ems_map_t map);
    logic [3:0] hits;
    logic [3:0] nibble;
    logic       io_req;
    io_req = !b.io_read_n || !b.io_write_n;
    case (base_code)
        2'd0:    nibble = 4'hA;
        2'd1:    nibble = 4'hC;
        default: nibble = 4'hD;
    endcase
    for (int i = 0; i < 4; i++) begin
        hits[i] = !io_req && map[i].enable && (b.address[19:16] == nibble)
                  && (b.address[15:14] == i[1:0]);
    end
    return hits;
endfunction

// Returns {drive, data}
function automatic logic [8:0] expect_read(cpu_bus_t b, io_select_t s, ems_map_t map,
                                           periph_data_t p, logic [7:0] lpt);
    ems_entry_t e;
    logic       rd;
    rd = !b.io_read_n;
    e  = map[b.address[1:0]];
    if (!b.interrupt_acknowledge_n) return {1'b1, p.intc};
    if (s.intc && rd)  return {1'b1, p.intc};
    if (s.timer && rd) return {1'b1, p.timer};
    if (s.ppi && rd)   return {1'b1, p.ppi};
    if (s.ems && rd)   return {1'b1, (e.enable ? {1'b0, e.page} : 8'hFF)};
    if (s.lpt && rd)   return {1'b1, lpt};
    return 9'h000;
endfunction

`endif

// File: test/tb_xt_glue.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Random testbench for xt_glue_top against the model in xt_glue_model.
// Outputs are checked mid-cycle, inputs change 2 ns after each edge.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_xt_glue
    import xt_bus_pkg::*;
    import xt_ems_pkg::*;
();

    localparam int          CLOCK_PERIOD   = 20;
    localparam int          RESET_CYCLES   = 2;
    localparam int          RANDOM_CYCLES  = 3000;
    localparam int          TIMEOUT_CYCLES = RESET_CYCLES + RANDOM_CYCLES + 100;
    localparam int unsigned SEED           = 32'h2cc20b72;

    logic         clock;
    logic         reset;
    cpu_bus_t     bus;
    logic         ems_enabled;
    logic [1:0]   ems_base;
    logic         peripheral_clock;
    logic [7:0]   keycode;
    logic         keyboard_irq;
    periph_data_t periph_data;
    io_select_t   select;
    ems_map_t     ems_map;
    logic [3:0]   ems_window;
    logic         timer_clock;
    logic [7:0]   port_a;
    logic         keyboard_interrupt;
    logic [7:0]   data_bus;
    logic         data_bus_drive;

    // Model state
    ems_map_t     model_map;
    ems_entry_t   pend_entry;
    ems_entry_t   new_entry;
    logic [1:0]   pend_index;
    logic         pend_valid;
    logic [7:0]   lpt_latch;
    logic [8:0]   exp_read;
    io_select_t   exp_select;
    logic [8:0]   kbd_hist0;
    logic [8:0]   kbd_hist1;
    logic         last_timer_clock;
    int           hold_count;
    int           settle_count;
    int           rise_count;
    int           toggle_count;
    int           check_count;
    int           error_count;
    int unsigned  seed_value;

    `include "xt_glue_model.svh"

    xt_glue_top dut_i (
        .clock                (clock),
        .reset                (reset),
        .bus_i                (bus),
        .ems_enabled_i        (ems_enabled),
        .ems_base_i           (ems_base),
        .peripheral_clock_i   (peripheral_clock),
        .keycode_i            (keycode),
        .keyboard_irq_i       (keyboard_irq),
        .periph_data_i        (periph_data),
        .select_o             (select),
        .ems_map_o            (ems_map),
        .ems_window_o         (ems_window),
        .timer_clock_o        (timer_clock),
        .port_a_o             (port_a),
        .keyboard_interrupt_o (keyboard_interrupt),
        .data_bus_o           (data_bus),
        .data_bus_drive_o     (data_bus_drive)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR t=%0t %s: got %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    // Address mix leans on EMS, LPT and chip ports
    task automatic drive_random_inputs();
        logic [31:0] r;
        logic [31:0] r2;
        logic [3:0]  nibble;
        r  = $urandom;
        r2 = $urandom;
        case (r[2:0])
            3'd0, 3'd1: bus.address = {4'h0, EMS_PORT_BASE[15:2], r[9:8]};
            3'd2:       bus.address = {4'h0, LPT_PORT_BASE[15:3], r[10:8]};
            3'd3, 3'd4: bus.address = {12'h000, r2[7:0]};
            3'd5: begin
                case (r[9:8])
                    2'd0:    nibble = 4'hA;
                    2'd1:    nibble = 4'hC;
                    2'd2:    nibble = 4'hD;
                    default: nibble = r2[19:16];
                endcase
                bus.address = {nibble, r2[15:0]};
            end
            default:    bus.address = r2[19:0];
        endcase
        case (r[24:23])
            2'd0:    bus.data = 8'hFF;
            2'd1:    bus.data = {1'b0, r2[26:20]};
            2'd2:    bus.data = {1'b1, r2[26:20]};
            default: bus.data = r2[31:24];
        endcase
        bus.io_read_n               = (r[12:11] != 2'd0);
        bus.io_write_n              = (r[12:11] != 2'd1);
        bus.memory_read_n           = !(r[12] && r[13]);
        bus.address_enable_n        = (r[18:16] == 3'd0);
        bus.interrupt_acknowledge_n = (r[22:19] != 4'd0);
        ems_enabled  = (r[27:25] != 3'd0);
        ems_base     = r[29:28];
        keyboard_irq = r[30];
        keycode      = 8'($urandom);
        periph_data  = 24'($urandom);
    endtask

    task automatic step_peripheral_clock();
        if (hold_count == 0) begin
            peripheral_clock = ~peripheral_clock;
            hold_count       = $urandom_range(6, 3);
            if (peripheral_clock) begin
                rise_count++;
                settle_count = 4;
            end
        end
        hold_count--;
    endtask

    // Mid-cycle compare, then step the model past the next edge
    task automatic check_and_advance();
        exp_select = expect_select(bus, ems_enabled);
        check_value("select_o", select, exp_select);
        check_value("ems_window_o", ems_window, expect_window(bus, ems_base, model_map));
        check_value("ems_map_o", ems_map, model_map);
        check_value("data_bus_o", data_bus, exp_read[7:0]);
        check_value("data_bus_drive_o", data_bus_drive, exp_read[8]);
        check_value("port_a_o", port_a, kbd_hist1[7:0]);
        check_value("keyboard_interrupt_o", keyboard_interrupt, kbd_hist1[8]);

        if (timer_clock !== last_timer_clock) toggle_count++;
        last_timer_clock = timer_clock;
        if (settle_count > 0) begin
            settle_count--;
            if (settle_count == 0) begin
                check_value("timer_clock_o toggles", toggle_count, rise_count);
            end
        end

        exp_read  = expect_read(bus, exp_select, model_map, periph_data, lpt_latch);
        kbd_hist1 = kbd_hist0;
        kbd_hist0 = {keyboard_irq, keycode};
        if (exp_select.lpt && !bus.io_write_n) lpt_latch = bus.data;

        // Sampled write resolves against the map as it is now
        new_entry = resolve_ems_write(bus.data, model_map[bus.address[1:0]]);
        if (pend_valid) model_map[pend_index] = pend_entry;
        pend_valid = exp_select.ems && !bus.io_write_n;
        pend_index = bus.address[1:0];
        pend_entry = new_entry;
    endtask

    initial begin
        #(TIMEOUT_CYCLES * CLOCK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        seed_value = $urandom(SEED);
        reset      = 1'b1;
        bus        = '0;
        bus.io_read_n               = 1'b1;
        bus.io_write_n              = 1'b1;
        bus.memory_read_n           = 1'b1;
        bus.address_enable_n        = 1'b1;
        bus.interrupt_acknowledge_n = 1'b1;
        ems_enabled      = 1'b0;
        ems_base         = 2'd0;
        peripheral_clock = 1'b0;
        keycode          = 8'h00;
        keyboard_irq     = 1'b0;
        periph_data      = '0;

        model_map        = '0;
        pend_entry       = '0;
        pend_index       = 2'd0;
        pend_valid       = 1'b0;
        lpt_latch        = 8'hFF;
        exp_read         = 9'h000;
        kbd_hist0        = 9'h000;
        kbd_hist1        = 9'h000;
        last_timer_clock = 1'b0;
        hold_count       = 3;
        settle_count     = 0;
        rise_count       = 0;
        toggle_count     = 0;
        check_count      = 0;
        error_count      = 0;

        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        reset = 1'b0;

        for (int cycle = 0; cycle < RANDOM_CYCLES; cycle++) begin
            drive_random_inputs();
            step_peripheral_clock();
            #8;
            check_and_advance();
            @(posedge clock);
            #2;
        end

        $display("Checks: %0d, errors: %0d, timer rises: %0d, timer toggles: %0d",
                 check_count, error_count, rise_count, toggle_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end
        else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
